/* logic/fifo_pkg.sv */
// Sample queue shared types

package fifo_pkg;

  // Width of each level field in the status word
  localparam int LEVEL_W = 8;

  // Host-visible word width
  localparam int REC_W = 48;

  // Wishbone word addresses
  localparam logic ADR_RECORD = 1'b0;
  localparam logic ADR_STATUS = 1'b1;

  // Tag lane payload
  typedef struct packed {
    logic [3:0]  channel;
    logic [11:0] seq;
  } tag_t;

  // Joined record, tag in the upper bits
  typedef struct packed {
    tag_t        tag;
    logic [31:0] data;
  } record_t;

  // Status word returned at ADR_STATUS
  typedef struct packed {
    logic [LEVEL_W-1:0]         tag_level;
    logic [LEVEL_W-1:0]         data_level;
    logic                       rec_valid;
    // Zero fill up to the record width
    logic [REC_W-2*LEVEL_W-2:0] pad;
  } status_t;

endpackage

/* logic/sp_sram.sv */
// Single-port synchronous RAM

module sp_sram #(
  parameter int  DEPTH     = 8,
  parameter type payload_t = logic [31:0]
) (
  input  logic                                   CLK,
  input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] addr,
  input  logic                                   we,
  input  payload_t                               wdata,
  output payload_t                               rdata
);

  // Storage array
  payload_t mem [DEPTH];

  // One port per cycle
  // Write when enabled, otherwise read the addressed entry
  always_ff @(posedge CLK) begin
    if (we) begin
      mem[addr] <= wdata;
    end else begin
      // Read data registered, valid next cycle
      rdata <= mem[addr];
    end
  end

endmodule

/* logic/sram_fifo.sv */
// FIFO on one single-port SRAM
// Occupancy counted, read wins the port

module sram_fifo #(
  parameter int  DEPTH     = 8,
  parameter type payload_t = logic [31:0]
) (
  input  logic                         CLK,
  input  logic                         RESET,
  input  logic                         push,
  input  payload_t                     din,
  input  logic                         pop,
  output logic                         ready,
  output payload_t                     dout,
  output logic                         rd_valid,
  output logic                         empty,
  output logic [fifo_pkg::LEVEL_W-1:0] level
);

  // Pointer and counter widths
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [AW-1:0] rd_ptr;
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] next_rd_ptr;
  logic [AW-1:0] next_wr_ptr;
  logic [AW-1:0] mem_addr;
  logic [CW-1:0] count;
  logic          full;
  logic          do_push;
  logic          do_pop;

  // All DEPTH slots usable
  assign full  = (count == CW'(DEPTH));
  assign empty = (count == '0);

  // Port busy with a read whenever pop is high
  assign ready = !full && !pop;

  // Accepted operations
  assign do_push = push && ready;
  // Pop on empty is dropped
  assign do_pop  = pop && !empty;

  assign level = fifo_pkg::LEVEL_W'(count);

  // Wrap at DEPTH
  assign next_wr_ptr = (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
  assign next_rd_ptr = (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

  // Shared address, read pointer during a pop
  assign mem_addr = pop ? rd_ptr : wr_ptr;

  sp_sram #(
    .DEPTH     (DEPTH),
    .payload_t (payload_t)
  ) u_sram (
    .CLK   (CLK),
    .addr  (mem_addr),
    .we    (do_push),
    .wdata (din),
    .rdata (dout)
  );

  // Pointers and occupancy
  always_ff @(posedge CLK) begin
    if (RESET) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_wr_ptr;
      end
      if (do_pop) begin
        rd_ptr <= next_rd_ptr;
      end
      // Push and pop never coincide, ready is low during pop
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // SRAM read data lands one cycle after the pop
  always_ff @(posedge CLK) begin
    if (RESET) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= do_pop;
    end
  end

endmodule

/* logic/record_joiner.sv */
// Tag/data joiner with Wishbone slave

module record_joiner (
  input  logic                         CLK,
  input  logic                         RESET,
  // Tag lane
  input  logic                         tag_empty,
  input  logic                         tag_rd_valid,
  input  fifo_pkg::tag_t               tag_dout,
  input  logic [fifo_pkg::LEVEL_W-1:0] tag_level,
  // Data lane
  input  logic                         data_empty,
  input  logic                         data_rd_valid,
  input  logic [31:0]                  data_dout,
  input  logic [fifo_pkg::LEVEL_W-1:0] data_level,
  // Wishbone classic slave
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic                         wb_adr,
  output logic                         pop,
  output logic [fifo_pkg::REC_W-1:0]   wb_dat_o,
  output logic                         wb_ack
);

  fifo_pkg::record_t rec;
  fifo_pkg::status_t status;
  logic              rec_valid;
  logic              in_flight;
  logic              rd_pair;
  logic              wb_req;
  logic              rec_read;
  logic              ack_next;

  // Paired pop, only with a free slot and nothing pending
  assign pop = !tag_empty && !data_empty && !rec_valid && !in_flight;

  // Both lanes return together
  assign rd_pair = tag_rd_valid && data_rd_valid;

  // Live status word
  assign status = '{tag_level:  tag_level,
                    data_level: data_level,
                    rec_valid:  rec_valid,
                    pad:        '0};

  // Bus request, one ack per strobe
  assign wb_req   = wb_cyc && wb_stb && !wb_ack;
  assign rec_read = !wb_we && (wb_adr == fifo_pkg::ADR_RECORD);
  // Record reads wait for a held record
  assign ack_next = wb_req && (!rec_read || rec_valid);

  // Record slot and in-flight flag
  always_ff @(posedge CLK) begin
    if (RESET) begin
      rec_valid <= 1'b0;
      in_flight <= 1'b0;
    end else begin
      if (pop) begin
        in_flight <= 1'b1;
      end else if (rd_pair) begin
        in_flight <= 1'b0;
      end
      // Capture and consume never overlap
      if (rd_pair) begin
        rec_valid <= 1'b1;
      end else if (ack_next && rec_read) begin
        rec_valid <= 1'b0;
      end
    end
  end

  // Record payload
  always_ff @(posedge CLK) begin
    if (rd_pair) begin
      rec <= '{tag: tag_dout, data: data_dout};
    end
  end

  // Ack and read data
  always_ff @(posedge CLK) begin
    if (RESET) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= ack_next;
    end
  end

  always_ff @(posedge CLK) begin
    if (ack_next) begin
      // Writes return status, ignored by the host
      wb_dat_o <= rec_read ? rec : status;
    end
  end

endmodule

/* logic/sample_queue_top.sv */
// Two-lane sample queue top

module sample_queue_top #(
  parameter int DEPTH = 8
) (
  input  logic                       CLK,
  input  logic                       RESET,
  // Tag producer
  input  logic                       tag_push,
  input  fifo_pkg::tag_t             tag_in,
  // Data producer
  input  logic                       data_push,
  input  logic [31:0]                data_in,
  // Host bus
  input  logic                       wb_cyc,
  input  logic                       wb_stb,
  input  logic                       wb_we,
  input  logic                       wb_adr,
  output logic                       tag_ready,
  output logic                       data_ready,
  output logic [fifo_pkg::REC_W-1:0] wb_dat_o,
  output logic                       wb_ack
);

  // Shared pop to both lanes
  logic pop;

  // Tag lane outputs
  fifo_pkg::tag_t               tag_dout;
  logic                         tag_rd_valid;
  logic                         tag_empty;
  logic [fifo_pkg::LEVEL_W-1:0] tag_level;

  // Data lane outputs
  logic [31:0]                  data_dout;
  logic                         data_rd_valid;
  logic                         data_empty;
  logic [fifo_pkg::LEVEL_W-1:0] data_level;

  sram_fifo #(
    .DEPTH     (DEPTH),
    .payload_t (fifo_pkg::tag_t)
  ) u_tag_fifo (
    .CLK      (CLK),
    .RESET    (RESET),
    .push     (tag_push),
    .din      (tag_in),
    .pop      (pop),
    .ready    (tag_ready),
    .dout     (tag_dout),
    .rd_valid (tag_rd_valid),
    .empty    (tag_empty),
    .level    (tag_level)
  );

  sram_fifo #(
    .DEPTH     (DEPTH),
    .payload_t (logic [31:0])
  ) u_data_fifo (
    .CLK      (CLK),
    .RESET    (RESET),
    .push     (data_push),
    .din      (data_in),
    .pop      (pop),
    .ready    (data_ready),
    .dout     (data_dout),
    .rd_valid (data_rd_valid),
    .empty    (data_empty),
    .level    (data_level)
  );

  record_joiner u_joiner (
    .CLK           (CLK),
    .RESET         (RESET),
    .tag_empty     (tag_empty),
    .tag_rd_valid  (tag_rd_valid),
    .tag_dout      (tag_dout),
    .tag_level     (tag_level),
    .data_empty    (data_empty),
    .data_rd_valid (data_rd_valid),
    .data_dout     (data_dout),
    .data_level    (data_level),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .pop           (pop),
    .wb_dat_o      (wb_dat_o),
    .wb_ack        (wb_ack)
  );

endmodule

/* dv/sample_queue_sva.sv */
// FIFO protocol assertions

module sram_fifo_sva #(
  parameter int DEPTH = 8,
  parameter int AW    = 3
) (
  input logic                         CLK,
  input logic                         RESET,
  input logic                         push,
  input logic                         pop,
  input logic                         ready,
  input logic                         empty,
  input logic                         rd_valid,
  input logic [fifo_pkg::LEVEL_W-1:0] level,
  input logic [AW-1:0]                rd_ptr,
  input logic [AW-1:0]                wr_ptr
);

  timeunit 1ns;
  timeprecision 100ps;

  // Occupancy bound
  a_level_max: assert property (@(posedge CLK) disable iff (RESET) level <= DEPTH)
    else $error("FIFO level above DEPTH");

  // Read data one cycle after an effective pop
  a_pop_valid: assert property (@(posedge CLK) disable iff (RESET)
    (pop && !empty) |=> rd_valid)
    else $error("rd_valid missing after pop");

  // Full FIFO refuses pushes
  a_full_ready: assert property (@(posedge CLK) disable iff (RESET)
    (level == DEPTH) |-> !ready)
    else $error("ready high while full");

  // Pointers move only on accepted operations
  a_wr_hold: assert property (@(posedge CLK) disable iff (RESET)
    !(push && ready) |=> $stable(wr_ptr))
    else $error("write pointer moved without a push");

  a_rd_hold: assert property (@(posedge CLK) disable iff (RESET)
    !(pop && !empty) |=> $stable(rd_ptr))
    else $error("read pointer moved without a pop");

endmodule

// Covers both lanes
bind sram_fifo sram_fifo_sva #(
  .DEPTH (DEPTH),
  .AW    (AW)
) u_fifo_sva (
  .CLK      (CLK),
  .RESET    (RESET),
  .push     (push),
  .pop      (pop),
  .ready    (ready),
  .empty    (empty),
  .rd_valid (rd_valid),
  .level    (level),
  .rd_ptr   (rd_ptr),
  .wr_ptr   (wr_ptr)
);

/* dv/sample_queue_tb.sv */
// Sample queue testbench

module sample_queue_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DEPTH        = 8;
  localparam int CLK_PERIOD   = 20;
  localparam int DRIVE_DLY    = 2;
  localparam int RESET_CYCLES = 8;
  localparam int STEP_CYCLES  = 40;
  localparam int SEED         = 35167;

  typedef enum logic [2:0] {
    OP_PUSH_TAG, OP_PUSH_DATA, OP_READ_REC, OP_READ_EMPTY,
    OP_READ_STATUS, OP_WRITE, OP_IDLE, OP_CHECK_READY
  } op_e;

  // Operand is a count, a cycle number or an address
  typedef struct packed {
    op_e         op;
    logic [7:0]  operand;
    logic [47:0] expected;
    logic [2:0]  test;
  } step_t;

  logic                       CLK;
  logic                       RESET;
  logic                       tag_push;
  fifo_pkg::tag_t             tag_in;
  logic                       data_push;
  logic [31:0]                data_in;
  logic                       wb_cyc;
  logic                       wb_stb;
  logic                       wb_we;
  logic                       wb_adr;
  logic                       tag_ready;
  logic                       data_ready;
  logic [fifo_pkg::REC_W-1:0] wb_dat_o;
  logic                       wb_ack;

  // Pushed but not yet read, in push order
  fifo_pkg::tag_t tag_q[$];
  logic [31:0]    data_q[$];
  step_t          steps[$];
  int             errors;
  int             checks;
  int             errors_base;
  string          test_name [1:6] = '{"reset state", "tag/data pairing", "data lane full",
                                      "record read on empty queue", "levels after idle",
                                      "write has no effect"};

  sample_queue_top #(.DEPTH(DEPTH)) dut0 (.*);

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  task automatic check_value(input logic [47:0] got, input logic [47:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0d ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic [47:0] status_word(int tag_lvl, int data_lvl, bit valid);
    fifo_pkg::status_t s;
    s = '0;
    s.tag_level  = fifo_pkg::LEVEL_W'(tag_lvl);
    s.data_level = fifo_pkg::LEVEL_W'(data_lvl);
    s.rec_valid  = valid;
    return s;
  endfunction

  function automatic void add_step(op_e op, int operand, logic [47:0] exp, int test);
    steps.push_back('{op: op, operand: 8'(operand), expected: exp, test: 3'(test)});
  endfunction

  // Run order 1, 2, 4, 3, 5, 6 so the queue is empty for test 4
  function automatic void build_table();
    add_step(OP_CHECK_READY, 0, 48'b110, 1);
    add_step(OP_READ_STATUS, 0, status_word(0, 0, 0), 1);
    add_step(OP_PUSH_TAG, 2, '0, 2);
    add_step(OP_PUSH_DATA, 1, '0, 2);
    add_step(OP_PUSH_TAG, 1, '0, 2);
    add_step(OP_IDLE, 2, '0, 2);
    add_step(OP_PUSH_DATA, 2, '0, 2);
    add_step(OP_READ_REC, 3, '0, 2);
    add_step(OP_READ_EMPTY, 6, '0, 4);
    add_step(OP_PUSH_DATA, DEPTH, '0, 3);
    add_step(OP_CHECK_READY, 0, 48'b100, 3);
    add_step(OP_READ_STATUS, 0, status_word(0, 8, 0), 3);
    add_step(OP_PUSH_TAG, 1, '0, 3);
    add_step(OP_IDLE, 4, '0, 3);
    add_step(OP_CHECK_READY, 0, 48'b110, 3);
    add_step(OP_READ_STATUS, 0, status_word(0, 7, 1), 3);
    add_step(OP_PUSH_TAG, 2, '0, 5);
    add_step(OP_READ_REC, 1, '0, 5);
    add_step(OP_IDLE, 4, '0, 5);
    add_step(OP_READ_STATUS, 0, status_word(1, 6, 1), 5);
    add_step(OP_WRITE, fifo_pkg::ADR_RECORD, '0, 6);
    add_step(OP_READ_STATUS, 0, status_word(1, 6, 1), 6);
    add_step(OP_READ_REC, 2, '0, 6);
    add_step(OP_IDLE, 4, '0, 6);
    add_step(OP_READ_STATUS, 0, status_word(0, 5, 0), 6);
  endfunction

  // Called and returns at DRIVE_DLY after a rising edge
  task automatic wb_access(input logic we, input logic adr, output logic [47:0] dat);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    do @(negedge CLK); while (!wb_ack);
    dat = wb_dat_o;
    @(posedge CLK);
    #DRIVE_DLY;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  // Held until ready seen high before the edge
  task automatic push_tag();
    logic [15:0] r;
    r = 16'($urandom);
    tag_q.push_back(r);
    tag_push = 1'b1;
    tag_in   = r;
    do @(negedge CLK); while (!tag_ready);
    @(posedge CLK);
    #DRIVE_DLY;
    tag_push = 1'b0;
  endtask

  task automatic push_data();
    logic [31:0] d;
    d = $urandom;
    data_q.push_back(d);
    data_push = 1'b1;
    data_in   = d;
    do @(negedge CLK); while (!data_ready);
    @(posedge CLK);
    #DRIVE_DLY;
    data_push = 1'b0;
  endtask

  task automatic read_record();
    logic [47:0] dat;
    logic [47:0] exp;
    wb_access(1'b0, fifo_pkg::ADR_RECORD, dat);
    // i-th tag with i-th data word
    exp = {tag_q.pop_front(), data_q.pop_front()};
    check_value(dat, exp, "record read");
  endtask

  // Read stalls until a pair arrives
  task automatic read_while_empty(input int wait_cycles);
    logic [47:0] dat;
    logic [47:0] exp;
    fork
      wb_access(1'b0, fifo_pkg::ADR_RECORD, dat);
      begin
        repeat (wait_cycles) begin
          @(negedge CLK);
          check_value(wb_ack, 1'b0, "ack during empty record read");
        end
        @(posedge CLK);
        #DRIVE_DLY;
        push_tag();
        push_data();
      end
    join
    exp = {tag_q.pop_front(), data_q.pop_front()};
    check_value(dat, exp, "stalled record read");
  endtask

  task automatic run_step(input step_t s);
    logic [47:0] dat;
    case (s.op)
      OP_PUSH_TAG:   repeat (s.operand) push_tag();
      OP_PUSH_DATA:  repeat (s.operand) push_data();
      OP_READ_REC:   repeat (s.operand) read_record();
      OP_READ_EMPTY: read_while_empty(s.operand);
      OP_READ_STATUS: begin
        wb_access(1'b0, fifo_pkg::ADR_STATUS, dat);
        check_value(dat, s.expected, "status read");
      end
      OP_WRITE: wb_access(1'b1, s.operand[0], dat);
      OP_IDLE: begin
        repeat (s.operand) @(posedge CLK);
        #DRIVE_DLY;
      end
      default: begin
        // Flags sampled mid-cycle
        @(negedge CLK);
        check_value({tag_ready, data_ready, wb_ack}, s.expected, "tag_ready/data_ready/wb_ack");
        @(posedge CLK);
        #DRIVE_DLY;
      end
    endcase
  endtask

  initial begin
    void'($urandom(SEED));
    CLK       = 1'b0;
    RESET     = 1'b1;
    tag_push  = 1'b0;
    tag_in    = '0;
    data_push = 1'b0;
    data_in   = '0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = 1'b0;
    errors    = 0;
    checks    = 0;
    build_table();
    // Watchdog sized from the table length
    fork
      begin
        #((steps.size() * STEP_CYCLES + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the allotted time");
        $display("*** FAILED ***");
        $finish;
      end
    join_none
    repeat (RESET_CYCLES) @(posedge CLK);
    #DRIVE_DLY;
    RESET = 1'b0;
    errors_base = 0;
    foreach (steps[i]) begin
      run_step(steps[i]);
      if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test) begin
        $display("Test %0d (%s): %0d errors", steps[i].test, test_name[steps[i].test],
                 errors - errors_base);
        errors_base = errors;
      end
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* sim.f */
logic/fifo_pkg.sv
logic/sp_sram.sv
logic/sram_fifo.sv
logic/record_joiner.sv
logic/sample_queue_top.sv
dv/sample_queue_sva.sv
dv/sample_queue_tb.sv

/* Bender.yml */
package:
  name: sample_queue

sources:
  # Shared types first
  - logic/fifo_pkg.sv
  - logic/sp_sram.sv
  - logic/sram_fifo.sv
  - logic/record_joiner.sv
  - logic/sample_queue_top.sv
  - target: test
    files:
      - dv/sample_queue_sva.sv
      - dv/sample_queue_tb.sv
